// ==== sim.f ====
src/be_pkg.sv
src/be_ifs.sv
src/be_decode.sv
src/be_execute.sv
src/be_result.sv
src/be_top.sv
sim/be_tb.sv

// ==== sim/be_tb.sv ====
// Back-end testbench
`default_nettype none

module be_tb;
   import be_pkg::*;

   localparam int DATA_WIDTH = 32;
   localparam int DMEM_WORDS = 16;
   localparam int PROG_LEN   = 64;
   localparam be_pc_t END_PC = PROG_LEN * 4;
   // Reset, 20 cycles per instruction and a drain window
   localparam int LIMIT      = 8 + PROG_LEN * 20 + 20;

   typedef logic [DATA_WIDTH-1:0] data_t;

   typedef struct packed {
      be_pc_t       pc;
      be_reg_addr_t rd;
      data_t        data;
   } commit_s;

   logic         clk_i            = 1'b0;
   logic         rst_n_i          = 1'b0;
   logic         fe_queue_v_i     = 1'b0;
   be_pc_t       fe_queue_pc_i    = '0;
   be_instr_s    fe_queue_instr_i = '0;
   logic         fe_queue_yumi_o;
   logic         fe_cmd_v_o;
   be_pc_t       fe_cmd_pc_o;
   logic         fe_cmd_ready_i   = 1'b0;
   logic         commit_v_o;
   be_pc_t       commit_pc_o;
   be_reg_addr_t commit_rd_o;
   data_t        commit_data_o;

   // Program and architectural state
   be_instr_s prog [PROG_LEN];
   data_t     regs [8] = '{default: '0};
   data_t     dmem [DMEM_WORDS] = '{default: '0};
   be_pc_t    m_pc = '0;
   be_pc_t    fe_pc = '0;
   int        cycles = 0;
   int        commits = 0;
   int        pc_errs = 0;
   int        rd_errs = 0;
   int        data_errs = 0;
   int        other_errs = 0;

   be_top #(.DATA_WIDTH(DATA_WIDTH), .DMEM_WORDS(DMEM_WORDS)) be_top_inst (.*);

   initial begin
      forever #50 clk_i = ~clk_i;
   end

   // Retires the instruction at m_pc
   function automatic commit_s ref_step();
      be_instr_s ins;
      data_t     a;
      data_t     b;
      data_t     imm;
      data_t     addr;
      logic      taken;
      commit_s   c;
      ins  = prog[m_pc >> 2];
      a    = regs[ins.rs1];
      b    = regs[ins.rs2];
      imm  = data_t'($signed(ins.imm));
      addr = (a + imm) >> 2;
      c.pc = m_pc;
      c.rd = ins.rd;
      m_pc = m_pc + 4;
      case (ins.op)
         OP_ADD:  c.data = a + b;
         OP_SUB:  c.data = a - b;
         OP_AND:  c.data = a & b;
         OP_OR:   c.data = a | b;
         OP_XOR:  c.data = a ^ b;
         OP_SLL:  c.data = a << b[4:0];
         OP_SRL:  c.data = a >> b[4:0];
         OP_ADDI: c.data = a + imm;
         OP_LUI:  c.data = imm << 16;
         OP_LD:   c.data = dmem[addr % DMEM_WORDS];
         default: c.data = '0;
      endcase
      if (ins.op == OP_ST) begin
         dmem[addr % DMEM_WORDS] = b;
         c.data = b;
      end
      if (ins.op == OP_BEQ || ins.op == OP_BNE) begin
         // BEQ jumps on equal sources, BNE on unequal ones
         taken = (ins.op == OP_BEQ) ? (a == b) : (a != b);
         if (taken)
            m_pc = c.pc + be_pc_t'(imm << 2);
         c.data = data_t'(m_pc);
      end
      // Stores, branches, NOP and illegal codes write nothing
      if (ins.op == OP_NOP || ins.op > OP_LD)
         c.rd = '0;
      if (c.rd != '0)
         regs[c.rd] = c.data;
      return c;
   endfunction

   task automatic check_pc(be_pc_t got, be_pc_t exp);
      if (got !== exp) begin
         $display("ERROR commit_pc_o got %h expected %h", got, exp);
         pc_errs++;
      end
   endtask

   task automatic check_rd(be_reg_addr_t got, be_reg_addr_t exp);
      if (got !== exp) begin
         $display("ERROR commit_rd_o got %h expected %h", got, exp);
         rd_errs++;
      end
   endtask

   task automatic check_data(data_t got, data_t exp);
      if (got !== exp) begin
         $display("ERROR commit_data_o got %h expected %h", got, exp);
         data_errs++;
      end
   endtask

   task automatic report_counts();
      $display("Commits %0d, errors: pc %0d rd %0d data %0d other %0d",
               commits, pc_errs, rd_errs, data_errs, other_errs);
   endtask

   always @(posedge clk_i) begin : compare
      commit_s exp;
      if (rst_n_i && commit_v_o) begin
         if (m_pc >= END_PC) begin
            $display("Commit seen after the last program instruction retired");
            other_errs++;
         end else begin
            exp = ref_step();
            check_pc(commit_pc_o, exp.pc);
            check_rd(commit_rd_o, exp.rd);
            check_data(commit_data_o, exp.data);
            commits++;
         end
      end
   end

   // Front end holds each offer until yumi or redirect
   always @(posedge clk_i) begin : fe_model
      be_pc_t pc_n;
      logic   redirect;
      redirect = fe_cmd_v_o && fe_cmd_ready_i;
      pc_n = fe_pc;
      if (redirect)
         pc_n = fe_cmd_pc_o;
      else if (fe_queue_yumi_o)
         pc_n = fe_pc + 4;
      fe_pc          <= pc_n;
      fe_cmd_ready_i <= ($urandom % 4) != 0;
      if (!fe_queue_v_i || fe_queue_yumi_o || redirect) begin
         fe_queue_v_i     <= rst_n_i && pc_n < END_PC && ($urandom % 4) != 0;
         fe_queue_pc_i    <= pc_n;
         fe_queue_instr_i <= prog[pc_n >> 2];
      end
   end

   always @(posedge clk_i) begin : watchdog
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout, the program did not retire within %0d cycles", LIMIT);
         report_counts();
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin : main
      logic [3:0]  op;
      logic [15:0] imm;
      void'($urandom(32'h9d2a_469c));
      for (int i = 0; i < PROG_LEN; i++) begin
         op  = 4'($urandom);
         imm = 16'($urandom);
         // Small offsets so loads often meet earlier stores
         if (op == OP_LD || op == OP_ST)
            imm = imm % 64;
         // Forward branches only, never past the program end
         if (op == OP_BEQ || op == OP_BNE)
            imm = 16'(1 + $urandom % 3);
         if ((op == OP_BEQ || op == OP_BNE) && i + imm > PROG_LEN)
            imm = 16'(PROG_LEN - i);
         prog[i] = {op, 3'($urandom), 3'($urandom), 3'($urandom), 3'b000, imm};
      end
      // Store wraps onto word 1, load it back, taken BEQ, not-taken BNE, illegal op
      prog[0] = {OP_ADDI, 3'd1, 3'd0, 3'd0, 3'b000, 16'h8421};
      prog[1] = {OP_ST, 3'd0, 3'd0, 3'd1, 3'b000, 16'(4 * (DMEM_WORDS + 1))};
      prog[2] = {OP_LD, 3'd2, 3'd0, 3'd0, 3'b000, 16'h0004};
      prog[3] = {OP_BEQ, 3'd0, 3'd2, 3'd1, 3'b000, 16'h0002};
      prog[5] = {OP_BNE, 3'd0, 3'd1, 3'd2, 3'b000, 16'h0003};
      prog[6] = {4'hf, 3'd3, 3'd1, 3'd2, 3'b000, 16'h0001};
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      wait (m_pc >= END_PC);
      repeat (20) @(posedge clk_i);
      report_counts();
      if (pc_errs + rd_errs + data_errs + other_errs == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/be_decode.sv ====
// Decode and issue stage
`default_nettype none

module be_decode
 #(parameter int DATA_WIDTH = 32)
  (input  logic                clk_i
   , input  logic              rst_n_i

   , input  logic              fe_queue_v_i
   , input  be_pkg::be_pc_t    fe_queue_pc_i
   , input  be_pkg::be_instr_s fe_queue_instr_i
   , output logic              fe_queue_yumi_o

   , be_dispatch_if.producer   dispatch
   , be_result_if.consumer     result
   );

   import be_pkg::*;

   typedef be_pkt_types#(DATA_WIDTH)::dispatch_pkt_s dispatch_pkt_t;

   logic [DATA_WIDTH-1:0] rf_q [8];
   logic [7:0]            busy_q;
   logic                  br_pending_q;

   // Issue slot holding the entry taken from the queue
   logic                  issue_v_q;
   be_pc_t                issue_pc_q;
   be_instr_s             issue_instr_q;

   be_opcode_e            op;
   be_reg_addr_t          rd;
   logic                  is_branch;
   logic                  hazard;
   logic                  issue_go;
   dispatch_pkt_t         pkt_n;

   always_comb begin
      case (issue_instr_q.op)
         OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
         OP_ADDI, OP_LUI, OP_LD, OP_ST, OP_BEQ, OP_BNE:
            op = issue_instr_q.op;
         default:
            op = OP_NOP;
      endcase
   end

   // Only register writers keep their destination
   always_comb begin
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
         OP_ADDI, OP_LUI, OP_LD:
            rd = issue_instr_q.rd;
         default:
            rd = '0;
      endcase
   end

   assign is_branch = (op == OP_BEQ) || (op == OP_BNE);

   assign hazard = br_pending_q
                 | busy_q[issue_instr_q.rs1]
                 | busy_q[issue_instr_q.rs2]
                 | busy_q[rd];

   assign issue_go = issue_v_q && !hazard && (!dispatch.v || dispatch.ready);

   // Nothing enters behind a branch until it resolves
   assign fe_queue_yumi_o = fe_queue_v_i && !br_pending_q
                         && !(issue_v_q && is_branch)
                         && (!issue_v_q || issue_go);

   always_comb begin
      pkt_n.pc      = issue_pc_q;
      pkt_n.op      = op;
      pkt_n.rd      = rd;
      pkt_n.rs1_val = rf_q[issue_instr_q.rs1];
      pkt_n.rs2_val = rf_q[issue_instr_q.rs2];
      pkt_n.imm     = DATA_WIDTH'($signed(issue_instr_q.imm));
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         issue_v_q    <= 1'b0;
         dispatch.v   <= 1'b0;
         busy_q       <= '0;
         br_pending_q <= 1'b0;
         for (int i = 0; i < 8; i++)
            rf_q[i] <= '0;
      end else begin
         if (fe_queue_yumi_o)
            issue_v_q <= 1'b1;
         else if (issue_go)
            issue_v_q <= 1'b0;

         if (issue_go)
            dispatch.v <= 1'b1;
         else if (dispatch.ready)
            dispatch.v <= 1'b0;

         if (result.wb_v)
            busy_q[result.wb_rd] <= 1'b0;
         if (issue_go && rd != '0)
            busy_q[rd] <= 1'b1;

         if (issue_go && is_branch)
            br_pending_q <= 1'b1;
         else if (result.br_resolve)
            br_pending_q <= 1'b0;

         if (result.wb_v && result.wb_rd != '0)
            rf_q[result.wb_rd] <= result.wb_data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fe_queue_yumi_o) begin
         issue_pc_q    <= fe_queue_pc_i;
         issue_instr_q <= fe_queue_instr_i;
      end
      if (issue_go)
         dispatch.pkt <= pkt_n;
   end

   // An offer not taken stays until yumi or a redirect
   a_offer_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fe_queue_v_i && !fe_queue_yumi_o && !result.br_resolve
      |=> fe_queue_v_i && $stable(fe_queue_pc_i));

   // A writeback always retires a register marked busy at dispatch
   a_wb_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      result.wb_v |-> busy_q[result.wb_rd]);

endmodule

`default_nettype wire

// ==== src/be_execute.sv ====
// Execute stage
`default_nettype none

module be_execute
 #(parameter int DATA_WIDTH = 32)
  (input  logic              clk_i
   , input  logic            rst_n_i

   , be_dispatch_if.consumer dispatch
   , be_exec_if.producer     exec
   );

   import be_pkg::*;

   typedef be_pkt_types#(DATA_WIDTH)::exec_pkt_s exec_pkt_t;

   logic [DATA_WIDTH-1:0] a;
   logic [DATA_WIDTH-1:0] b;
   logic [DATA_WIDTH-1:0] imm;
   logic                  accept;
   exec_pkt_t             pkt_n;

   assign a   = dispatch.pkt.rs1_val;
   assign b   = dispatch.pkt.rs2_val;
   assign imm = dispatch.pkt.imm;

   assign dispatch.ready = !exec.v || exec.ready;
   assign accept         = dispatch.v && dispatch.ready;

   always_comb begin
      pkt_n.pc         = dispatch.pkt.pc;
      pkt_n.op         = dispatch.pkt.op;
      pkt_n.rd         = dispatch.pkt.rd;
      pkt_n.store_data = b;
      pkt_n.br_taken   = 1'b0;
      // Branch offset counts instructions
      pkt_n.br_target  = dispatch.pkt.pc + {imm[29:0], 2'b00};
      pkt_n.result     = '0;

      case (dispatch.pkt.op)
         OP_ADD:
            pkt_n.result = a + b;
         OP_SUB:
            pkt_n.result = a - b;
         OP_AND:
            pkt_n.result = a & b;
         OP_OR:
            pkt_n.result = a | b;
         OP_XOR:
            pkt_n.result = a ^ b;
         OP_SLL:
            pkt_n.result = a << b[4:0];
         OP_SRL:
            pkt_n.result = a >> b[4:0];
         OP_LUI:
            pkt_n.result = imm << 16;
         OP_ADDI, OP_LD, OP_ST:
            pkt_n.result = a + imm;
         OP_BEQ, OP_BNE: begin
            pkt_n.result   = DATA_WIDTH'(dispatch.pkt.pc + 32'd4);
            pkt_n.br_taken = (dispatch.pkt.op == OP_BEQ) == (a == b);
         end
         default: begin
            pkt_n.result = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exec.v <= 1'b0;
      end else begin
         if (accept)
            exec.v <= 1'b1;
         else if (exec.ready)
            exec.v <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept)
         exec.pkt <= pkt_n;
   end

   a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exec.v && !exec.ready |=> exec.v && $stable(exec.pkt));

endmodule

`default_nettype wire

// ==== src/be_ifs.sv ====
// Back-end stage interfaces
`default_nettype none

interface be_dispatch_if #(parameter int DATA_WIDTH = 32);
   import be_pkg::*;

   logic                                        v;
   logic                                        ready;
   be_pkt_types#(DATA_WIDTH)::dispatch_pkt_s    pkt;

   modport producer (output v, output pkt, input ready);
   modport consumer (input v, input pkt, output ready);
endinterface

interface be_exec_if #(parameter int DATA_WIDTH = 32);
   import be_pkg::*;

   logic                                        v;
   logic                                        ready;
   be_pkt_types#(DATA_WIDTH)::exec_pkt_s        pkt;

   modport producer (output v, output pkt, input ready);
   modport consumer (input v, input pkt, output ready);
endinterface

// Writeback and branch resolution back into decode
interface be_result_if #(parameter int DATA_WIDTH = 32);
   import be_pkg::*;

   logic                  wb_v;
   be_reg_addr_t          wb_rd;
   logic [DATA_WIDTH-1:0] wb_data;
   logic                  br_resolve;

   modport producer (
      output wb_v,
      output wb_rd,
      output wb_data,
      output br_resolve
   );

   modport consumer (
      input wb_v,
      input wb_rd,
      input wb_data,
      input br_resolve
   );
endinterface

`default_nettype wire

// ==== src/be_pkg.sv ====
// Back-end shared types
`default_nettype none

package be_pkg;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_SLL  = 4'h6,
      OP_SRL  = 4'h7,
      OP_ADDI = 4'h8,
      OP_LUI  = 4'h9,
      OP_LD   = 4'ha,
      OP_ST   = 4'hb,
      OP_BEQ  = 4'hc,
      OP_BNE  = 4'hd
   } be_opcode_e;

   // Register 0 reads as zero
   typedef logic [2:0]  be_reg_addr_t;
   typedef logic [31:0] be_pc_t;

   typedef struct packed {
      be_opcode_e   op;
      be_reg_addr_t rd;
      be_reg_addr_t rs1;
      be_reg_addr_t rs2;
      logic [2:0]   unused;
      logic [15:0]  imm;
   } be_instr_s;

   // Stage packets sized by the datapath width
   virtual class be_pkt_types #(parameter int DATA_WIDTH = 32);

      typedef struct packed {
         be_pc_t                pc;
         be_opcode_e            op;
         be_reg_addr_t          rd;
         logic [DATA_WIDTH-1:0] rs1_val;
         logic [DATA_WIDTH-1:0] rs2_val;
         logic [DATA_WIDTH-1:0] imm;
      } dispatch_pkt_s;

      typedef struct packed {
         be_pc_t                pc;
         be_opcode_e            op;
         be_reg_addr_t          rd;
         logic [DATA_WIDTH-1:0] result;
         logic [DATA_WIDTH-1:0] store_data;
         logic                  br_taken;
         be_pc_t                br_target;
      } exec_pkt_s;

   endclass

endpackage

`default_nettype wire

// ==== src/be_result.sv ====
// Result stage with data scratchpad
`default_nettype none

module be_result
 #(parameter int DATA_WIDTH = 32
   , parameter int DMEM_WORDS = 16)
  (input  logic                     clk_i
   , input  logic                   rst_n_i

   , be_exec_if.consumer            exec
   , be_result_if.producer          result

   , output logic                   fe_cmd_v_o
   , output be_pkg::be_pc_t         fe_cmd_pc_o
   , input  logic                   fe_cmd_ready_i

   , output logic                   commit_v_o
   , output be_pkg::be_pc_t         commit_pc_o
   , output be_pkg::be_reg_addr_t   commit_rd_o
   , output logic [DATA_WIDTH-1:0]  commit_data_o
   );

   import be_pkg::*;

   localparam int AW = $clog2(DMEM_WORDS);

   logic [DATA_WIDTH-1:0] dmem_q [DMEM_WORDS];
   logic [AW-1:0]         dmem_idx;
   logic [DATA_WIDTH-1:0] data_n;
   logic                  accept;
   logic                  taken;
   logic                  is_branch;
   logic                  redirect_done;
   logic                  br_nt_q;
   be_pc_t                br_pc_q;

   // Hold the pipe while a redirect waits
   assign exec.ready = !fe_cmd_v_o;

   assign accept        = exec.v && exec.ready;
   assign taken         = exec.pkt.br_taken;
   assign is_branch     = (exec.pkt.op == OP_BEQ) || (exec.pkt.op == OP_BNE);
   assign redirect_done = fe_cmd_v_o && fe_cmd_ready_i;

   // Word address wraps around the scratchpad
   assign dmem_idx = exec.pkt.result[2 +: AW];

   always_comb begin
      case (exec.pkt.op)
         OP_LD:
            data_n = dmem_q[dmem_idx];
         OP_ST:
            data_n = exec.pkt.store_data;
         default:
            data_n = exec.pkt.result;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         commit_v_o <= 1'b0;
         br_nt_q    <= 1'b0;
         fe_cmd_v_o <= 1'b0;
         for (int i = 0; i < DMEM_WORDS; i++)
            dmem_q[i] <= '0;
      end else begin
         commit_v_o <= (accept && !taken) || redirect_done;
         br_nt_q    <= accept && !taken && is_branch;

         if (accept && taken)
            fe_cmd_v_o <= 1'b1;
         else if (redirect_done)
            fe_cmd_v_o <= 1'b0;

         if (accept && exec.pkt.op == OP_ST)
            dmem_q[dmem_idx] <= exec.pkt.store_data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && taken) begin
         fe_cmd_pc_o <= exec.pkt.br_target;
         br_pc_q     <= exec.pkt.pc;
      end

      if (accept && !taken) begin
         commit_pc_o   <= exec.pkt.pc;
         commit_rd_o   <= exec.pkt.rd;
         commit_data_o <= data_n;
      end else if (redirect_done) begin
         // Taken branch retires with its target as next pc
         commit_pc_o   <= br_pc_q;
         commit_rd_o   <= '0;
         commit_data_o <= DATA_WIDTH'(fe_cmd_pc_o);
      end
   end

   assign result.wb_v       = commit_v_o && (commit_rd_o != '0);
   assign result.wb_rd      = commit_rd_o;
   assign result.wb_data    = commit_data_o;
   assign result.br_resolve = br_nt_q || redirect_done;

   a_redirect_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fe_cmd_v_o && !fe_cmd_ready_i |=> fe_cmd_v_o && $stable(fe_cmd_pc_o));

endmodule

`default_nettype wire

// ==== src/be_top.sv ====
// Processor back-end top
`default_nettype none

module be_top
 #(parameter int DATA_WIDTH = 32
   , parameter int DMEM_WORDS = 16)
  (input  logic                     clk_i
   , input  logic                   rst_n_i

   // Front-end queue
   , input  logic                   fe_queue_v_i
   , input  be_pkg::be_pc_t         fe_queue_pc_i
   , input  be_pkg::be_instr_s      fe_queue_instr_i
   , output logic                   fe_queue_yumi_o

   // Redirect command
   , output logic                   fe_cmd_v_o
   , output be_pkg::be_pc_t         fe_cmd_pc_o
   , input  logic                   fe_cmd_ready_i

   // Retired instructions
   , output logic                   commit_v_o
   , output be_pkg::be_pc_t         commit_pc_o
   , output be_pkg::be_reg_addr_t   commit_rd_o
   , output logic [DATA_WIDTH-1:0]  commit_data_o
   );

   be_dispatch_if #(.DATA_WIDTH(DATA_WIDTH)) dispatch_if ();
   be_exec_if     #(.DATA_WIDTH(DATA_WIDTH)) exec_if ();
   be_result_if   #(.DATA_WIDTH(DATA_WIDTH)) result_if ();

   be_decode
    #(.DATA_WIDTH(DATA_WIDTH))
    decode_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_pc_i(fe_queue_pc_i)
      ,.fe_queue_instr_i(fe_queue_instr_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.dispatch(dispatch_if)
      ,.result(result_if)
      );

   be_execute
    #(.DATA_WIDTH(DATA_WIDTH))
    execute_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.dispatch(dispatch_if)
      ,.exec(exec_if)
      );

   be_result
    #(.DATA_WIDTH(DATA_WIDTH)
      ,.DMEM_WORDS(DMEM_WORDS))
    result_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.exec(exec_if)
      ,.result(result_if)
      ,.fe_cmd_v_o(fe_cmd_v_o)
      ,.fe_cmd_pc_o(fe_cmd_pc_o)
      ,.fe_cmd_ready_i(fe_cmd_ready_i)
      ,.commit_v_o(commit_v_o)
      ,.commit_pc_o(commit_pc_o)
      ,.commit_rd_o(commit_rd_o)
      ,.commit_data_o(commit_data_o)
      );

endmodule

`default_nettype wire
